/* Bender.yml */
package:
  name: mspe

sources:
  - hdl/mspe_pkg.sv
  - hdl/mspe_decode.sv
  - hdl/mspe_execute.sv
  - hdl/mspe_result.sv
  - hdl/mspe_top.sv
  - target: test
    files:
      - tb/mspe_tb.sv

/* hdl/mspe_decode.sv */
`default_nettype none

module mspe_decode import mspe_pkg::*; #(
    parameter int REG_COUNT = 32
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     insn_valid,
    input  word_t    insn,
    output decoded_t dec
);

    opcode_t  opcode;
    funct3_t  funct3;
    funct7_t  funct7;
    logic     uses_rs1;
    logic     uses_rs2;
    logic     bad_enc;
    logic     bad_idx;
    decoded_t dec_d;

    assign opcode = insn[6:0];
    assign funct3 = insn[14:12];
    assign funct7 = insn[31:25];

    always_comb begin
        dec_d     = '0;
        dec_d.rd  = insn[11:7];
        dec_d.rs1 = insn[19:15];
        dec_d.rs2 = insn[24:20];
        dec_d.op  = ALU_ADD;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        bad_enc   = 1'b0;

        case (opcode)
            OPC_OP_IMM: begin
                uses_rs1      = 1'b1;
                dec_d.use_imm = 1'b1;
                dec_d.imm     = {{20{insn[31]}}, insn[31:20]};
                case (funct3)
                    F3_ADD:  dec_d.op = ALU_ADD;
                    F3_SLT:  dec_d.op = ALU_SLT;
                    F3_XOR:  dec_d.op = ALU_XOR;
                    F3_OR:   dec_d.op = ALU_OR;
                    F3_AND:  dec_d.op = ALU_AND;
                    default: bad_enc  = 1'b1; // Shifts and SLTIU
                endcase
            end
            OPC_OP: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                if (funct7 == F7_ALT && funct3 == F3_ADD) begin
                    dec_d.op = ALU_SUB;
                end else if (funct7 != F7_BASE) begin
                    bad_enc = 1'b1;
                end else begin
                    case (funct3)
                        F3_ADD:  dec_d.op = ALU_ADD;
                        F3_SLT:  dec_d.op = ALU_SLT;
                        F3_XOR:  dec_d.op = ALU_XOR;
                        F3_OR:   dec_d.op = ALU_OR;
                        F3_AND:  dec_d.op = ALU_AND;
                        default: bad_enc  = 1'b1;
                    endcase
                end
            end
            OPC_LUI: begin
                dec_d.rs1     = '0;
                dec_d.use_imm = 1'b1;
                dec_d.imm     = {insn[31:12], 12'b0};
                dec_d.op      = ALU_PASS;
            end
            default: bad_enc = 1'b1;
        endcase

        // Only fields that name a register are range checked
        bad_idx = (dec_d.rd >= REG_COUNT)
                || (uses_rs1 && dec_d.rs1 >= REG_COUNT)
                || (uses_rs2 && dec_d.rs2 >= REG_COUNT);

        dec_d.valid   = insn_valid;
        dec_d.illegal = insn_valid && (bad_enc || bad_idx);
        dec_d.wr_en   = insn_valid && !dec_d.illegal && (dec_d.rd != '0);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec <= '0;
        end else begin
            dec <= dec_d;
        end
    end

endmodule

`default_nettype wire

/* hdl/mspe_execute.sv */
`default_nettype none

module mspe_execute import mspe_pkg::*; #(
    parameter int REG_COUNT = 32
) (
    input  logic     clk,
    input  logic     rst,
    input  decoded_t dec,
    output reg_idx_t rs1_addr,
    output reg_idx_t rs2_addr,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    output exec_t    exe
);

    // Legal indices never use the bits above this width
    localparam int IDX_W = $clog2(REG_COUNT);

    logic  fwd_a;
    logic  fwd_b;
    word_t op_a;
    word_t rs2_val;
    word_t op_b;
    word_t alu_out;
    exec_t exe_d;

    assign rs1_addr = dec.rs1;
    assign rs2_addr = dec.rs2;

    // Producer one cycle older has not reached the register file yet
    assign fwd_a = exe.valid && exe.wr_en
                && (exe.rd[IDX_W-1:0] == dec.rs1[IDX_W-1:0]);
    assign fwd_b = exe.valid && exe.wr_en
                && (exe.rd[IDX_W-1:0] == dec.rs2[IDX_W-1:0]);

    assign op_a    = fwd_a ? exe.data : rs1_data;
    assign rs2_val = fwd_b ? exe.data : rs2_data;
    assign op_b    = dec.use_imm ? dec.imm : rs2_val;

    always_comb begin
        case (dec.op)
            ALU_ADD:  alu_out = op_a + op_b;
            ALU_SUB:  alu_out = op_a - op_b;
            ALU_XOR:  alu_out = op_a ^ op_b;
            ALU_OR:   alu_out = op_a | op_b;
            ALU_AND:  alu_out = op_a & op_b;
            ALU_SLT:  alu_out = {{31{1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_PASS: alu_out = op_b; // Upper immediate
            default:  alu_out = '0;
        endcase
    end

    always_comb begin
        exe_d.valid   = dec.valid;
        exe_d.illegal = dec.illegal;
        exe_d.rd      = dec.rd;
        exe_d.wr_en   = dec.valid && dec.wr_en;
        exe_d.data    = alu_out;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exe <= '0;
        end else begin
            exe <= exe_d;
        end
    end

endmodule

`default_nettype wire

/* hdl/mspe_pkg.sv */
`default_nettype none

package mspe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_LUI    = 7'b0110111;

    localparam funct3_t F3_ADD = 3'b000; // ADD, SUB, ADDI
    localparam funct3_t F3_SLT = 3'b010;
    localparam funct3_t F3_XOR = 3'b100;
    localparam funct3_t F3_OR  = 3'b110;
    localparam funct3_t F3_AND = 3'b111;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000; // Selects SUB

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLT,
        ALU_PASS // LUI
    } alu_op_e;

    typedef struct packed {
        logic     valid;
        logic     illegal;
        alu_op_e  op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic     use_imm;
        word_t    imm;
        logic     wr_en;
    } decoded_t;

    typedef struct packed {
        logic     valid;
        logic     illegal;
        reg_idx_t rd;
        logic     wr_en;
        word_t    data;
    } exec_t;

    typedef struct packed {
        reg_idx_t rd;
        word_t    data;
        logic     illegal;
    } result_t;

endpackage

`default_nettype wire

/* hdl/mspe_result.sv */
`default_nettype none

module mspe_result import mspe_pkg::*; #(
    parameter int REG_COUNT = 32
) (
    input  logic     clk,
    input  logic     rst,
    input  exec_t    exe,
    input  reg_idx_t rs1_addr,
    input  reg_idx_t rs2_addr,
    output word_t    rs1_data,
    output word_t    rs2_data,
    output logic     res_valid,
    output result_t  res
);

    localparam int IDX_W = $clog2(REG_COUNT);

    word_t            regs [REG_COUNT];
    logic [IDX_W-1:0] rd1_idx;
    logic [IDX_W-1:0] rd2_idx;
    logic [IDX_W-1:0] wr_idx;

    assign rd1_idx = rs1_addr[IDX_W-1:0];
    assign rd2_idx = rs2_addr[IDX_W-1:0];
    assign wr_idx  = exe.rd[IDX_W-1:0];

    // x0 is hardwired to zero
    assign rs1_data = (rd1_idx == '0) ? '0 : regs[rd1_idx];
    assign rs2_data = (rd2_idx == '0) ? '0 : regs[rd2_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            res_valid <= 1'b0;
            res       <= '0;
        end else begin
            res_valid <= exe.valid;
            if (exe.valid) begin
                if (exe.wr_en) begin
                    regs[wr_idx] <= exe.data;
                end
                res.rd      <= exe.rd;
                res.data    <= exe.illegal ? '0 : exe.data;
                res.illegal <= exe.illegal;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/mspe_top.sv */
`default_nettype none

module mspe_top import mspe_pkg::*; #(
    parameter int REG_COUNT = 32 // 16 for RV32E
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    insn_valid,
    input  word_t   insn,
    output logic    res_valid,
    output result_t res
);

    decoded_t dec;
    exec_t    exe;
    reg_idx_t rs1_addr;
    reg_idx_t rs2_addr;
    word_t    rs1_data;
    word_t    rs2_data;

    mspe_decode #(
        .REG_COUNT (REG_COUNT)
    ) i_mspe_decode (
        .clk        (clk),
        .rst        (rst),
        .insn_valid (insn_valid),
        .insn       (insn),
        .dec        (dec)
    );

    mspe_execute #(
        .REG_COUNT (REG_COUNT)
    ) i_mspe_execute (
        .clk      (clk),
        .rst      (rst),
        .dec      (dec),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .exe      (exe)
    );

    // Register file lives here, read combinationally by execute
    mspe_result #(
        .REG_COUNT (REG_COUNT)
    ) i_mspe_result (
        .clk       (clk),
        .rst       (rst),
        .exe       (exe),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule

`default_nettype wire

/* tb/mspe_tb.sv */
`default_nettype none

module mspe_tb import mspe_pkg::*; ();

    localparam int N_DIRECTED     = 68;
    localparam int N_RANDOM       = 400;
    localparam int TIMEOUT_CYCLES = (N_DIRECTED + N_RANDOM) * 2 + 50;

    typedef struct packed {
        result_t     res;
        logic [31:0] due; // Cycle count at which the result is expected
    } pending_t;

    logic    clk;
    logic    rst;
    logic    insn_valid;
    word_t   insn;
    logic    res_valid;
    result_t res;

    integer   seed;
    int       cycle_cnt = 0;
    word_t    model_regs [32];
    pending_t exp_q [$];

    mspe_top #(
        .REG_COUNT (32)
    ) i_mspe_top (
        .clk        (clk),
        .rst        (rst),
        .insn_valid (insn_valid),
        .insn       (insn),
        .res_valid  (res_valid),
        .res        (res)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    function automatic word_t imm_insn(input logic [2:0] f3, input reg_idx_t rd,
                                       input reg_idx_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    function automatic word_t reg_insn(input logic [6:0] f7, input logic [2:0] f3,
                                       input reg_idx_t rd, input reg_idx_t rs1,
                                       input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic word_t lui_insn(input reg_idx_t rd, input logic [19:0] imm);
        return {imm, rd, 7'h37};
    endfunction

    // Expected result of one word against the model register file
    function automatic result_t ref_result(input word_t w);
        result_t    r;
        logic [2:0] f3;
        logic [6:0] f7;
        word_t      a;
        word_t      b;
        word_t      imm;
        f3        = w[14:12];
        f7        = w[31:25];
        a         = model_regs[w[19:15]];
        b         = model_regs[w[24:20]];
        imm       = {{20{w[31]}}, w[31:20]};
        r.rd      = w[11:7];
        r.data    = '0;
        r.illegal = 1'b0;
        case (w[6:0])
            7'h13: begin // OP-IMM
                case (f3)
                    3'b000:  r.data = a + imm;
                    3'b010:  r.data = {31'b0, $signed(a) < $signed(imm)};
                    3'b100:  r.data = a ^ imm;
                    3'b110:  r.data = a | imm;
                    3'b111:  r.data = a & imm;
                    default: r.illegal = 1'b1;
                endcase
            end
            7'h33: begin // OP
                if (f7 == 7'h20 && f3 == 3'b000) begin
                    r.data = a - b;
                end else if (f7 != 7'h00) begin
                    r.illegal = 1'b1;
                end else begin
                    case (f3)
                        3'b000:  r.data = a + b;
                        3'b010:  r.data = {31'b0, $signed(a) < $signed(b)};
                        3'b100:  r.data = a ^ b;
                        3'b110:  r.data = a | b;
                        3'b111:  r.data = a & b;
                        default: r.illegal = 1'b1;
                    endcase
                end
            end
            7'h37:   r.data = {w[31:12], 12'h000};
            default: r.illegal = 1'b1;
        endcase
        if (r.illegal) begin
            r.data = '0;
        end
        return r;
    endfunction

    task automatic clear_model();
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
    endtask

    task automatic issue_insn(input word_t w);
        result_t  r;
        pending_t p;
        @(negedge clk);
        insn_valid = 1'b1;
        insn       = w;
        r          = ref_result(w);
        if (!r.illegal && r.rd != '0) begin
            model_regs[r.rd] = r.data;
        end
        p.res = r;
        p.due = cycle_cnt + 3; // Sampled at the next edge, out three edges later
        exp_q.push_back(p);
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        insn_valid = 1'b0;
        insn       = '0;
    endtask

    task automatic drain();
        idle_cycle();
        while (exp_q.size() != 0) begin
            idle_cycle();
        end
    endtask

    task automatic random_insn(output word_t w, input reg_idx_t mask);
        int         kind;
        word_t      raw;
        logic [2:0] f3;
        kind = $random(seed) & 7;
        raw  = $random(seed);
        f3   = raw[14:12];
        if (f3 == 3'b001 || f3 == 3'b011 || f3 == 3'b101) begin
            f3[0] = 1'b0; // Fold shifts and SLTIU onto supported ops
        end
        case (kind)
            0, 1, 2: w = imm_insn(f3, raw[11:7] & mask, raw[19:15] & mask, raw[31:20]);
            3, 4: w = reg_insn((f3 == 3'b000 && raw[30]) ? 7'h20 : 7'h00, f3,
                               raw[11:7] & mask, raw[19:15] & mask, raw[24:20] & mask);
            5: w = lui_insn(raw[11:7] & mask, raw[31:12]);
            6: begin
                if (raw[0]) begin
                    w = reg_insn(7'h01, raw[14:12], raw[11:7] & mask, raw[19:15] & mask,
                                 raw[24:20] & mask);
                end else begin
                    w = imm_insn({raw[14:13], 1'b1}, raw[11:7] & mask, raw[19:15] & mask,
                                 raw[31:20]);
                end
            end
            default: w = raw; // Mostly unsupported opcodes
        endcase
    endtask

    // density 4 is back-to-back, 1 leaves a gap after most words
    task automatic random_stream(input int count, input int density, input reg_idx_t mask);
        word_t w;
        for (int i = 0; i < count; i++) begin
            random_insn(w, mask);
            issue_insn(w);
            if (($random(seed) & 3) >= density) begin
                idle_cycle();
            end
        end
        drain();
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_run("Timeout: the run did not finish within the cycle limit");
        end
    end

    always @(negedge clk) begin
        pending_t head;
        if (!rst) begin
            if (exp_q.size() == 0) begin
                if (res_valid !== 1'b0) begin
                    fail_run("Result strobe seen with no instruction pending");
                end
            end else if (res_valid !== 1'b0 || exp_q[0].due <= cycle_cnt) begin
                head = exp_q.pop_front();
                check_value("res_valid", res_valid, 1);
                check_value("res_valid cycle", cycle_cnt, head.due);
                check_value("res.rd", res.rd, head.res.rd);
                check_value("res.data", res.data, head.res.data);
                check_value("res.illegal", res.illegal, head.res.illegal);
            end
        end
    end

    initial begin
        rst        = 1'b1;
        insn_valid = 1'b0;
        insn       = '0;
        seed       = 32'h79a3_6bb1;
        clear_model();
        repeat (2) @(negedge clk);
        rst = 1'b0;
        repeat (4) idle_cycle(); // No strobe may appear here

        // Immediate operations with gaps
        issue_insn(imm_insn(3'b000, 5'd1, 5'd0, 12'hffb));
        idle_cycle();
        issue_insn(imm_insn(3'b100, 5'd2, 5'd1, 12'h0f0));
        idle_cycle();
        issue_insn(imm_insn(3'b110, 5'd3, 5'd2, 12'h123));
        idle_cycle();
        issue_insn(imm_insn(3'b111, 5'd4, 5'd3, 12'h7f0));
        idle_cycle();
        issue_insn(imm_insn(3'b010, 5'd5, 5'd1, 12'h003));
        idle_cycle();
        issue_insn(imm_insn(3'b010, 5'd6, 5'd3, 12'hf9c));
        idle_cycle();
        issue_insn(lui_insn(5'd7, 20'hdeadb));
        idle_cycle();
        issue_insn(imm_insn(3'b000, 5'd8, 5'd7, 12'h800));
        drain();

        // Register operations
        issue_insn(reg_insn(7'h00, 3'b000, 5'd9, 5'd1, 5'd7));
        issue_insn(reg_insn(7'h20, 3'b000, 5'd10, 5'd1, 5'd7));
        issue_insn(reg_insn(7'h00, 3'b100, 5'd11, 5'd3, 5'd7));
        issue_insn(reg_insn(7'h00, 3'b110, 5'd12, 5'd2, 5'd8));
        issue_insn(reg_insn(7'h00, 3'b111, 5'd13, 5'd7, 5'd3));
        issue_insn(reg_insn(7'h00, 3'b010, 5'd14, 5'd7, 5'd1));
        issue_insn(reg_insn(7'h00, 3'b010, 5'd15, 5'd1, 5'd7));
        drain();

        // Dependent chain at distances 1 to 3
        issue_insn(imm_insn(3'b000, 5'd16, 5'd0, 12'd100));
        issue_insn(imm_insn(3'b000, 5'd17, 5'd16, 12'd1));
        issue_insn(reg_insn(7'h00, 3'b000, 5'd18, 5'd16, 5'd17));
        issue_insn(reg_insn(7'h00, 3'b000, 5'd19, 5'd16, 5'd18));
        issue_insn(reg_insn(7'h20, 3'b000, 5'd20, 5'd19, 5'd17));
        issue_insn(reg_insn(7'h00, 3'b100, 5'd16, 5'd20, 5'd16));
        issue_insn(reg_insn(7'h00, 3'b010, 5'd21, 5'd16, 5'd20));
        issue_insn(reg_insn(7'h00, 3'b111, 5'd22, 5'd21, 5'd16));
        issue_insn(reg_insn(7'h00, 3'b000, 5'd23, 5'd22, 5'd22));
        issue_insn(imm_insn(3'b000, 5'd24, 5'd0, 12'd1));
        issue_insn(imm_insn(3'b000, 5'd24, 5'd0, 12'd2)); // Newest write must win
        issue_insn(reg_insn(7'h00, 3'b000, 5'd25, 5'd24, 5'd24));
        drain();

        // x0 writes and illegal words
        issue_insn(imm_insn(3'b000, 5'd0, 5'd0, 12'd123));
        issue_insn(reg_insn(7'h00, 3'b000, 5'd26, 5'd0, 5'd0));
        issue_insn(32'h0000_0000);
        issue_insn(imm_insn(3'b001, 5'd1, 5'd2, 12'h003));
        issue_insn(reg_insn(7'h01, 3'b000, 5'd2, 5'd3, 5'd4));
        issue_insn(reg_insn(7'h20, 3'b101, 5'd3, 5'd1, 5'd2));
        issue_insn({7'h00, 5'd1, 5'd2, 3'b010, 5'd3, 7'h23}); // Store
        issue_insn(reg_insn(7'h00, 3'b000, 5'd0, 5'd1, 5'd0));
        issue_insn(reg_insn(7'h00, 3'b000, 5'd0, 5'd2, 5'd0));
        issue_insn(reg_insn(7'h00, 3'b000, 5'd0, 5'd3, 5'd0));
        drain();

        // Random streams at falling density
        random_stream(100, 4, 5'h1f);
        random_stream(100, 3, 5'h07);
        random_stream(100, 2, 5'h1f);
        random_stream(100, 1, 5'h03);

        // Second reset, then every register reads back as zero
        @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        clear_model();
        repeat (4) idle_cycle();
        for (int i = 1; i < 32; i++) begin
            issue_insn(reg_insn(7'h00, 3'b000, 5'd0, reg_idx_t'(i), 5'd0));
        end
        drain();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hdl/mspe_pkg.sv
hdl/mspe_decode.sv
hdl/mspe_execute.sv
hdl/mspe_result.sv
hdl/mspe_top.sv
tb/mspe_tb.sv
